// File: hw/control_unit.sv
// purely combinational decode of the instruction in ir; no hazard detection
`default_nettype none

module control_unit (
    input  cpu_isa_pkg::instr_t          ir,
    output cpu_uarch_pkg::imm_kind_e     imm_kind,
    output cpu_uarch_pkg::alu_op_e       alu_op,
    output cpu_uarch_pkg::alu_b_sel_e    alu_b_sel,
    output logic                         mem_read,
    output logic                         mem_write,
    output logic                         reg_write,
    output logic                         pcwrite
);

    cpu_isa_pkg::opcode_e opcode;

    assign opcode = cpu_isa_pkg::opcode_e'(ir[cpu_isa_pkg::OPCODE_MSB:cpu_isa_pkg::OPCODE_LSB]);

    always_comb begin
        // bubble by default
        imm_kind  = cpu_uarch_pkg::IMM_SEXT4;
        alu_op    = cpu_uarch_pkg::ALU_ADD;
        alu_b_sel = cpu_uarch_pkg::B_ZERO;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        pcwrite   = 1'b1;

        case (opcode)
            cpu_isa_pkg::OP_ADD,
            cpu_isa_pkg::OP_SUB,
            cpu_isa_pkg::OP_AND,
            cpu_isa_pkg::OP_OR,
            cpu_isa_pkg::OP_XOR: begin
                alu_b_sel = cpu_uarch_pkg::B_REG;
                reg_write = 1'b1;
                case (opcode)
                    cpu_isa_pkg::OP_SUB: alu_op = cpu_uarch_pkg::ALU_SUB;
                    cpu_isa_pkg::OP_AND: alu_op = cpu_uarch_pkg::ALU_AND;
                    cpu_isa_pkg::OP_OR:  alu_op = cpu_uarch_pkg::ALU_OR;
                    cpu_isa_pkg::OP_XOR: alu_op = cpu_uarch_pkg::ALU_XOR;
                    default:             alu_op = cpu_uarch_pkg::ALU_ADD;
                endcase
            end
            cpu_isa_pkg::OP_ADDI: begin
                alu_b_sel = cpu_uarch_pkg::B_IMM;
                reg_write = 1'b1;
            end
            cpu_isa_pkg::OP_LI: begin
                imm_kind  = cpu_uarch_pkg::IMM_ZEXT8;
                alu_op    = cpu_uarch_pkg::ALU_PASS_B;
                alu_b_sel = cpu_uarch_pkg::B_IMM;
                reg_write = 1'b1;
            end
            cpu_isa_pkg::OP_LW: begin
                imm_kind  = cpu_uarch_pkg::IMM_ZEXT4;
                alu_b_sel = cpu_uarch_pkg::B_IMM;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            cpu_isa_pkg::OP_SW: begin
                imm_kind  = cpu_uarch_pkg::IMM_ZEXT4;
                alu_b_sel = cpu_uarch_pkg::B_IMM;
                mem_write = 1'b1;
            end
            // halt stalls fetch and issues bubbles
            cpu_isa_pkg::OP_HALT: pcwrite = 1'b0;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu_isa_pkg.sv
// 16-bit ISA shared by design and testbench; undefined opcodes execute as NOP
`default_nettype none

package cpu_isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] instr_t;
    typedef logic [3:0]  reg_idx_t;

    // codes 10 to 14 are unassigned
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LI   = 4'd7,
        OP_LW   = 4'd8,
        OP_SW   = 4'd9,
        OP_HALT = 4'd15
    } opcode_e;

    // field positions
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int RD_MSB     = 11;
    localparam int RD_LSB     = 8;
    localparam int RS_MSB     = 7;
    localparam int RS_LSB     = 4;
    // rt and imm4 share the low nibble
    localparam int RT_MSB     = 3;
    localparam int RT_LSB     = 0;
    localparam int IMM8_MSB   = 7;
    localparam int IMM8_LSB   = 0;

    localparam instr_t NOP_INSTR = '0;

endpackage

`default_nettype wire

// File: hw/cpu_uarch_pkg.sv
// pipeline-internal encodings; data memory is 16 words, addressed by the low address bits
`default_nettype none

package cpu_uarch_pkg;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    // second alu operand
    typedef enum logic [1:0] {
        B_REG  = 2'd0,
        B_IMM  = 2'd1,
        B_ZERO = 2'd2
    } alu_b_sel_e;

    typedef enum logic [1:0] {
        IMM_SEXT4 = 2'd0,
        IMM_ZEXT4 = 2'd1,
        IMM_ZEXT8 = 2'd2
    } imm_kind_e;

    localparam int REG_COUNT  = 16;
    localparam int DMEM_DEPTH = 16;

    typedef logic [3:0] dmem_addr_t;

endpackage

`default_nettype wire

// File: hw/decode_stage.sv
// register file with write-through and no forwarding; producers need three slots of distance
`default_nettype none

module decode_stage (
    input  logic                       clock,
    input  logic                       arst_n,
    input  cpu_isa_pkg::instr_t        ir,
    input  cpu_uarch_pkg::imm_kind_e   imm_kind,
    input  cpu_uarch_pkg::alu_op_e     alu_op_in,
    input  cpu_uarch_pkg::alu_b_sel_e  alu_b_sel_in,
    input  logic                       mem_read_in,
    input  logic                       mem_write_in,
    input  logic                       reg_write_in,
    input  logic                       wb_en,
    input  cpu_isa_pkg::reg_idx_t      wb_rd,
    input  cpu_isa_pkg::word_t         wb_data,
    output cpu_isa_pkg::word_t         a,
    output cpu_isa_pkg::word_t         b,
    output cpu_isa_pkg::word_t         imm,
    output cpu_isa_pkg::reg_idx_t      rd,
    output cpu_uarch_pkg::alu_op_e     alu_op,
    output cpu_uarch_pkg::alu_b_sel_e  alu_b_sel,
    output logic                       mem_read,
    output logic                       mem_write,
    output logic                       reg_write
);

    cpu_isa_pkg::word_t    regs [cpu_uarch_pkg::REG_COUNT];
    cpu_isa_pkg::reg_idx_t rd_idx;
    cpu_isa_pkg::reg_idx_t rs_idx;
    cpu_isa_pkg::reg_idx_t rb_idx;
    logic [3:0]            imm4;
    logic [7:0]            imm8;
    cpu_isa_pkg::word_t    a_next;
    cpu_isa_pkg::word_t    b_next;
    cpu_isa_pkg::word_t    imm_next;

    assign rd_idx = ir[cpu_isa_pkg::RD_MSB:cpu_isa_pkg::RD_LSB];
    assign rs_idx = ir[cpu_isa_pkg::RS_MSB:cpu_isa_pkg::RS_LSB];
    assign imm4   = ir[cpu_isa_pkg::RT_MSB:cpu_isa_pkg::RT_LSB];
    assign imm8   = ir[cpu_isa_pkg::IMM8_MSB:cpu_isa_pkg::IMM8_LSB];

    // store reads its data from rd on the second port
    assign rb_idx = mem_write_in ? rd_idx : imm4;

    // r0 is hardwired, then write-through, then the array
    assign a_next = (rs_idx == '0) ? '0 :
                    (wb_en && wb_rd == rs_idx) ? wb_data : regs[rs_idx];
    assign b_next = (rb_idx == '0) ? '0 :
                    (wb_en && wb_rd == rb_idx) ? wb_data : regs[rb_idx];

    always_comb begin
        case (imm_kind)
            cpu_uarch_pkg::IMM_ZEXT4: imm_next = cpu_isa_pkg::word_t'(imm4);
            cpu_uarch_pkg::IMM_ZEXT8: imm_next = cpu_isa_pkg::word_t'(imm8);
            default:                  imm_next = cpu_isa_pkg::word_t'($signed(imm4));
        endcase
    end

    // writes to r0 are dropped here
    always_ff @(posedge clock) begin
        if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
        end else begin
            mem_read  <= mem_read_in;
            mem_write <= mem_write_in;
            reg_write <= reg_write_in;
        end
    end

    always_ff @(posedge clock) begin
        a         <= a_next;
        b         <= b_next;
        imm       <= imm_next;
        rd        <= rd_idx;
        alu_op    <= alu_op_in;
        alu_b_sel <= alu_b_sel_in;
    end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
// single-cycle alu; add and sub wrap at the word width, no flags
`default_nettype none

module execute_stage (
    input  logic                       clock,
    input  logic                       arst_n,
    input  cpu_isa_pkg::word_t         a,
    input  cpu_isa_pkg::word_t         b,
    input  cpu_isa_pkg::word_t         imm,
    input  cpu_isa_pkg::reg_idx_t      rd_in,
    input  cpu_uarch_pkg::alu_op_e     alu_op,
    input  cpu_uarch_pkg::alu_b_sel_e  alu_b_sel,
    input  logic                       mem_read_in,
    input  logic                       mem_write_in,
    input  logic                       reg_write_in,
    output cpu_isa_pkg::word_t         alu_result,
    output cpu_isa_pkg::word_t         store_data,
    output cpu_isa_pkg::reg_idx_t      rd,
    output logic                       mem_read,
    output logic                       mem_write,
    output logic                       reg_write
);

    cpu_isa_pkg::word_t operand_b;
    cpu_isa_pkg::word_t result_next;

    always_comb begin
        case (alu_b_sel)
            cpu_uarch_pkg::B_REG: operand_b = b;
            cpu_uarch_pkg::B_IMM: operand_b = imm;
            default:              operand_b = '0;
        endcase
    end

    always_comb begin
        case (alu_op)
            cpu_uarch_pkg::ALU_SUB:    result_next = a - operand_b;
            cpu_uarch_pkg::ALU_AND:    result_next = a & operand_b;
            cpu_uarch_pkg::ALU_OR:     result_next = a | operand_b;
            cpu_uarch_pkg::ALU_XOR:    result_next = a ^ operand_b;
            cpu_uarch_pkg::ALU_PASS_B: result_next = operand_b;
            default:                   result_next = a + operand_b;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
        end else begin
            mem_read  <= mem_read_in;
            mem_write <= mem_write_in;
            reg_write <= reg_write_in;
        end
    end

    // store data rides along with the address
    always_ff @(posedge clock) begin
        alu_result <= result_next;
        store_data <= b;
        rd         <= rd_in;
    end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
// instruction memory must answer imem_addr combinationally; pc counts in words
`default_nettype none

module fetch_stage (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                pcwrite,
    output cpu_isa_pkg::word_t  imem_addr,
    input  cpu_isa_pkg::instr_t imem_data,
    output cpu_isa_pkg::instr_t ir
);

    cpu_isa_pkg::word_t pc;

    assign imem_addr = pc;

    // pc and ir freeze together while pcwrite is low
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            ir <= cpu_isa_pkg::NOP_INSTR;
        end else if (pcwrite) begin
            pc <= pc + cpu_isa_pkg::word_t'(1);
            ir <= imem_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/load_store_cpu.sv
// five-stage pipeline without interlocks; consumers must trail producers by three instructions
`default_nettype none

module load_store_cpu (
    input  logic                  clock,
    input  logic                  arst_n,
    output cpu_isa_pkg::word_t    imem_addr,
    input  cpu_isa_pkg::instr_t   imem_data,
    output logic                  halted,
    output logic                  retire_valid,
    output cpu_isa_pkg::reg_idx_t retire_rd,
    output cpu_isa_pkg::word_t    retire_data
);

    // fetch and control
    cpu_isa_pkg::instr_t        ir;
    logic                       pcwrite;
    cpu_uarch_pkg::imm_kind_e   ctl_imm_kind;
    cpu_uarch_pkg::alu_op_e     ctl_alu_op;
    cpu_uarch_pkg::alu_b_sel_e  ctl_alu_b_sel;
    logic                       ctl_mem_read;
    logic                       ctl_mem_write;
    logic                       ctl_reg_write;

    // decode to execute
    cpu_isa_pkg::word_t         de_a;
    cpu_isa_pkg::word_t         de_b;
    cpu_isa_pkg::word_t         de_imm;
    cpu_isa_pkg::reg_idx_t      de_rd;
    cpu_uarch_pkg::alu_op_e     de_alu_op;
    cpu_uarch_pkg::alu_b_sel_e  de_alu_b_sel;
    logic                       de_mem_read;
    logic                       de_mem_write;
    logic                       de_reg_write;

    // execute to memory
    cpu_isa_pkg::word_t         em_alu_result;
    cpu_isa_pkg::word_t         em_store_data;
    cpu_isa_pkg::reg_idx_t      em_rd;
    logic                       em_mem_read;
    logic                       em_mem_write;
    logic                       em_reg_write;

    // writeback, also the retire port
    logic                       wb_en;
    cpu_isa_pkg::reg_idx_t      wb_rd;
    cpu_isa_pkg::word_t         wb_data;

    assign halted       = ~pcwrite;
    assign retire_valid = wb_en;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

    fetch_stage fetch0 (
        .clock     (clock),
        .arst_n    (arst_n),
        .pcwrite   (pcwrite),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .ir        (ir)
    );

    control_unit control0 (
        .ir        (ir),
        .imm_kind  (ctl_imm_kind),
        .alu_op    (ctl_alu_op),
        .alu_b_sel (ctl_alu_b_sel),
        .mem_read  (ctl_mem_read),
        .mem_write (ctl_mem_write),
        .reg_write (ctl_reg_write),
        .pcwrite   (pcwrite)
    );

    decode_stage decode0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .ir           (ir),
        .imm_kind     (ctl_imm_kind),
        .alu_op_in    (ctl_alu_op),
        .alu_b_sel_in (ctl_alu_b_sel),
        .mem_read_in  (ctl_mem_read),
        .mem_write_in (ctl_mem_write),
        .reg_write_in (ctl_reg_write),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .a            (de_a),
        .b            (de_b),
        .imm          (de_imm),
        .rd           (de_rd),
        .alu_op       (de_alu_op),
        .alu_b_sel    (de_alu_b_sel),
        .mem_read     (de_mem_read),
        .mem_write    (de_mem_write),
        .reg_write    (de_reg_write)
    );

    execute_stage execute0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .a            (de_a),
        .b            (de_b),
        .imm          (de_imm),
        .rd_in        (de_rd),
        .alu_op       (de_alu_op),
        .alu_b_sel    (de_alu_b_sel),
        .mem_read_in  (de_mem_read),
        .mem_write_in (de_mem_write),
        .reg_write_in (de_reg_write),
        .alu_result   (em_alu_result),
        .store_data   (em_store_data),
        .rd           (em_rd),
        .mem_read     (em_mem_read),
        .mem_write    (em_mem_write),
        .reg_write    (em_reg_write)
    );

    mem_stage mem0 (
        .clock      (clock),
        .arst_n     (arst_n),
        .alu_result (em_alu_result),
        .store_data (em_store_data),
        .rd_in      (em_rd),
        .mem_read   (em_mem_read),
        .mem_write  (em_mem_write),
        .reg_write  (em_reg_write),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
// 16-word data memory, contents undefined after reset; upper address bits are ignored
`default_nettype none

module mem_stage (
    input  logic                  clock,
    input  logic                  arst_n,
    input  cpu_isa_pkg::word_t    alu_result,
    input  cpu_isa_pkg::word_t    store_data,
    input  cpu_isa_pkg::reg_idx_t rd_in,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  reg_write,
    output logic                  wb_en,
    output cpu_isa_pkg::reg_idx_t wb_rd,
    output cpu_isa_pkg::word_t    wb_data
);

    cpu_isa_pkg::word_t        dmem [cpu_uarch_pkg::DMEM_DEPTH];
    cpu_uarch_pkg::dmem_addr_t dmem_addr;
    cpu_isa_pkg::word_t        wb_data_next;

    // address wraps on the low bits
    assign dmem_addr = alu_result[$bits(cpu_uarch_pkg::dmem_addr_t)-1:0];

    always_ff @(posedge clock) begin
        if (mem_write) begin
            dmem[dmem_addr] <= store_data;
        end
    end

    // load data or alu result
    assign wb_data_next = mem_read ? dmem[dmem_addr] : alu_result;

    // r0 writes never reach writeback or retire
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= reg_write && (rd_in != '0);
        end
    end

    always_ff @(posedge clock) begin
        wb_rd   <= rd_in;
        wb_data <= wb_data_next;
    end

endmodule

`default_nettype wire

// File: load_store_cpu.f
hw/cpu_isa_pkg.sv
hw/cpu_uarch_pkg.sv
hw/control_unit.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/load_store_cpu.sv
test/tb_load_store_cpu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log shows the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f load_store_cpu.f --top-module tb_load_store_cpu -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/tb_load_store_cpu.sv
// random 200-instruction program; uses only r0-r14 as destinations and r15 as a fixed base
`default_nettype none

module tb_load_store_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN = 200;
    localparam int INIT_LEN = 15;
    localparam int TIMEOUT  = PROG_LEN + 50;
    localparam int DRAIN    = 6;
    localparam cpu_isa_pkg::word_t PROG_END   = 16'd200;
    localparam cpu_isa_pkg::word_t BASE_VALUE = 16'h00f8;

    logic                  clock;
    logic                  arst_n;
    cpu_isa_pkg::word_t    imem_addr;
    cpu_isa_pkg::instr_t   imem_data;
    logic                  halted;
    logic                  retire_valid;
    cpu_isa_pkg::reg_idx_t retire_rd;
    cpu_isa_pkg::word_t    retire_data;

    cpu_isa_pkg::instr_t   prog [256];
    logic [15:0]           lfsr_state;
    int                    last_write [16];
    logic                  stored [16];
    cpu_isa_pkg::reg_idx_t exp_rd_q [$];
    cpu_isa_pkg::word_t    exp_data_q [$];
    int                    exp_count;
    int                    retire_count;
    int                    cycle_count;
    int                    halt_cycles;
    cpu_isa_pkg::word_t    exp_pc;

    // past the end the fetch sees HALT
    assign imem_data = (imem_addr < PROG_END) ? prog[imem_addr[7:0]] : 16'hf000;

    load_store_cpu dut0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    // taps 16 14 13 11
    function automatic logic lfsr_feedback(input logic [15:0] s);
        return s[15] ^ s[13] ^ s[12] ^ s[10];
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] value;
        int          k;
        value = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[14:0], lfsr_feedback(lfsr_state)};
            value = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic cpu_isa_pkg::instr_t encode(input logic [3:0] op, input logic [3:0] rd,
                                                   input logic [3:0] rs, input logic [3:0] lo);
        return {op, rd, rs, lo};
    endfunction

    // falls back to r0 when the producer is too close
    function automatic cpu_isa_pkg::reg_idx_t pick_source(input int idx);
        cpu_isa_pkg::reg_idx_t r;
        r = 4'(take_bits(4));
        if (idx - last_write[r] < 3) begin
            r = '0;
        end
        return r;
    endfunction

    // r0 included, r15 stays the base
    function automatic cpu_isa_pkg::reg_idx_t pick_dest();
        int v;
        v = int'(take_bits(4)) % 15;
        return 4'(v);
    endfunction

    task automatic build_program();
        int                    i;
        int                    kind;
        cpu_isa_pkg::reg_idx_t rd;
        cpu_isa_pkg::reg_idx_t rs;
        cpu_isa_pkg::reg_idx_t rt;
        logic [3:0]            imm4;
        logic [7:0]            imm8;
        logic                  use_base;
        logic [3:0]            addr;
        for (i = 0; i < 16; i++) begin
            last_write[i] = -10;
            stored[i] = 1'b0;
        end
        // defined values everywhere before the random part
        for (i = 1; i < INIT_LEN; i++) begin
            imm8 = 8'(take_bits(8));
            prog[i-1] = encode(cpu_isa_pkg::OP_LI, 4'(i), imm8[7:4], imm8[3:0]);
            last_write[i] = i - 1;
        end
        prog[INIT_LEN-1] = encode(cpu_isa_pkg::OP_LI, 4'd15, BASE_VALUE[7:4], BASE_VALUE[3:0]);
        last_write[15] = INIT_LEN - 1;
        for (i = INIT_LEN; i < PROG_LEN - 1; i++) begin
            kind = int'(take_bits(4));
            rd = pick_dest();
            rs = pick_source(i);
            rt = pick_source(i);
            imm4 = 4'(take_bits(4));
            imm8 = 8'(take_bits(8));
            use_base = (take_bits(1) != 0) && (i - last_write[15] >= 3);
            // base r15 pushes the address past the top of the 16 words
            addr = use_base ? imm4 + BASE_VALUE[3:0] : imm4;
            if (kind <= 5) begin
                prog[i] = encode(4'(kind % 5 + 1), rd, rs, rt);
                last_write[rd] = i;
            end else if (kind <= 7) begin
                prog[i] = encode(cpu_isa_pkg::OP_ADDI, rd, rs, imm4);
                last_write[rd] = i;
            end else if (kind == 8) begin
                prog[i] = encode(cpu_isa_pkg::OP_LI, rd, imm8[7:4], imm8[3:0]);
                last_write[rd] = i;
            end else if ((kind >= 11 && kind <= 12) && stored[addr]) begin
                prog[i] = encode(cpu_isa_pkg::OP_LW, rd, use_base ? 4'd15 : 4'd0, imm4);
                last_write[rd] = i;
            end else if (kind <= 12) begin
                prog[i] = encode(cpu_isa_pkg::OP_SW, rt, use_base ? 4'd15 : 4'd0, imm4);
                stored[addr] = 1'b1;
            end else if (kind == 13) begin
                prog[i] = cpu_isa_pkg::NOP_INSTR;
            end else if (kind == 14) begin
                // unassigned opcode with junk fields
                prog[i] = encode(4'd10 + 4'(int'(imm4) % 5), rd, imm8[7:4], imm8[3:0]);
            end else begin
                prog[i] = encode(cpu_isa_pkg::OP_ADD, rd, 4'd0, rt);
                last_write[rd] = i;
            end
        end
        prog[PROG_LEN-1] = encode(cpu_isa_pkg::OP_HALT, 4'd0, 4'd0, 4'd0);
    endtask

    // sequential reference of the ISA
    task automatic run_model();
        cpu_isa_pkg::word_t    regs [16];
        cpu_isa_pkg::word_t    dmem [16];
        cpu_isa_pkg::word_t    result;
        cpu_isa_pkg::opcode_e  op;
        cpu_isa_pkg::reg_idx_t rd;
        cpu_isa_pkg::reg_idx_t rs;
        cpu_isa_pkg::reg_idx_t rt;
        logic [3:0]            addr;
        logic                  writes;
        int                    i;
        for (i = 0; i < 16; i++) begin
            regs[i] = '0;
            dmem[i] = '0;
        end
        exp_count = 0;
        for (i = 0; i < PROG_LEN; i++) begin
            op = cpu_isa_pkg::opcode_e'(prog[i][15:12]);
            rd = prog[i][11:8];
            rs = prog[i][7:4];
            rt = prog[i][3:0];
            addr = regs[rs][3:0] + rt;
            writes = 1'b1;
            result = '0;
            case (op)
                cpu_isa_pkg::OP_ADD:  result = regs[rs] + regs[rt];
                cpu_isa_pkg::OP_SUB:  result = regs[rs] - regs[rt];
                cpu_isa_pkg::OP_AND:  result = regs[rs] & regs[rt];
                cpu_isa_pkg::OP_OR:   result = regs[rs] | regs[rt];
                cpu_isa_pkg::OP_XOR:  result = regs[rs] ^ regs[rt];
                cpu_isa_pkg::OP_ADDI: result = regs[rs] + {{12{rt[3]}}, rt};
                cpu_isa_pkg::OP_LI:   result = {8'h00, prog[i][7:0]};
                cpu_isa_pkg::OP_LW:   result = dmem[addr];
                cpu_isa_pkg::OP_SW: begin
                    dmem[addr] = regs[rd];
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes && rd != 4'd0) begin
                regs[rd] = result;
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(result);
                exp_count++;
            end
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        assert (got === expected) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_cycle();
        assert (cycle_count < TIMEOUT) else fail_run("run did not finish within the cycle limit");
        check_word("imem_addr", imem_addr, exp_pc);
        check_word("halted", {15'd0, halted}, {15'd0, exp_pc == PROG_END});
        if (retire_valid) begin
            assert (exp_rd_q.size() != 0) else fail_run("retire pulse after the last model write");
            check_word("retire_rd", {12'd0, retire_rd}, {12'd0, exp_rd_q[0]});
            check_word("retire_data", retire_data, exp_data_q[0]);
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            retire_count++;
        end
        if (halted) begin
            halt_cycles++;
        end
        // pc stops once HALT is in ir
        if (exp_pc != PROG_END) begin
            exp_pc = exp_pc + 16'd1;
        end
        cycle_count++;
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        lfsr_state = 16'd7836;
        retire_count = 0;
        cycle_count = 0;
        halt_cycles = 0;
        exp_pc = '0;
        build_program();
        run_model();
        repeat (3) begin
            @(negedge clock);
            check_word("retire_valid", {15'd0, retire_valid}, 16'd0);
            check_word("halted", {15'd0, halted}, 16'd0);
        end
        arst_n = 1'b1;
        while (halt_cycles < DRAIN) begin
            check_cycle();
            @(negedge clock);
        end
        if (exp_rd_q.size() == 0 && retire_count == exp_count) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("retired %0d writes, model expects %0d", retire_count, exp_count);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
